// File: icache_pkg.sv
package icache_pkg;

    // cpu side word and memory side line
    localparam int WORD_W = 32;
    localparam int LINE_W = 128; // four words per line

    // geometry of one way
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 24;
    localparam int NUM_SETS = 2 ** INDEX_W; // 16 sets

    // one cpu address, seen either as a flat word or split into fields
    typedef union packed {
        logic [WORD_W-1:0] raw; // flat byte address
        struct packed {
            logic [TAG_W-1:0]   tag;      // compared against the way tags
            logic [INDEX_W-1:0] index;    // set select
            logic [1:0]         word;     // word inside the line
            logic [1:0]         byte_off; // unused, word accesses only
        } f;
    } icache_addr_u;

endpackage

// File: icache_way.sv
`timescale 1ns/100ps

module icache_way (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  logic [icache_pkg::TAG_W-1:0]   tag_i,    // tag of the cpu request
    input  logic                           we_i,     // write whole entry
    input  logic [icache_pkg::TAG_W-1:0]   wr_tag_i,
    input  logic                           wr_dirty_i,
    input  logic [icache_pkg::LINE_W-1:0]  wr_line_i,
    output logic                           hit_o,
    output logic                           valid_o,
    output logic                           dirty_o,
    output logic [icache_pkg::TAG_W-1:0]   tag_o,
    output logic [icache_pkg::LINE_W-1:0]  line_o
);

    // status bits per set
    logic [icache_pkg::NUM_SETS-1:0] valid_q;
    logic [icache_pkg::NUM_SETS-1:0] dirty_q;

    // payload arrays
    logic [icache_pkg::TAG_W-1:0]  tag_q  [icache_pkg::NUM_SETS];
    logic [icache_pkg::LINE_W-1:0] line_q [icache_pkg::NUM_SETS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0; // all entries empty
            dirty_q <= '0;
        end else if (we_i) begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= wr_dirty_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[index_i]  <= wr_tag_i;
            line_q[index_i] <= wr_line_i;
        end
    end

    // asynchronous read of the indexed set
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign tag_o   = tag_q[index_i];
    assign line_o  = line_q[index_i];

    assign hit_o = valid_o && (tag_o == tag_i); // tag match on a valid entry
endmodule

// File: icache_hit_merge.sv
`timescale 1ns/100ps

module icache_hit_merge #(
    parameter int NUM_WAYS = 4
) (
    input  logic [NUM_WAYS-1:0]                             way_hit_i,
    input  logic [NUM_WAYS-1:0]                             way_valid_i,
    input  logic [NUM_WAYS-1:0]                             way_dirty_i,
    input  logic [NUM_WAYS-1:0][icache_pkg::TAG_W-1:0]      way_tag_i,
    input  logic [NUM_WAYS-1:0][icache_pkg::LINE_W-1:0]     way_line_i,
    input  logic [$clog2(NUM_WAYS)-1:0]                     victim_way_i,
    output logic                                            hit_o,
    output logic [$clog2(NUM_WAYS)-1:0]                     hit_way_o,
    output logic [icache_pkg::LINE_W-1:0]                   hit_line_o,
    output logic [NUM_WAYS-1:0]                             valid_vec_o,
    output logic [icache_pkg::TAG_W-1:0]                    victim_tag_o,
    output logic                                            victim_dirty_o,
    output logic                                            victim_valid_o,
    output logic [icache_pkg::LINE_W-1:0]                   victim_line_o
);

    localparam int WAY_W = $clog2(NUM_WAYS);

    assign hit_o = |way_hit_i; // at most one way matches

    // encode the matching way and pick its line
    always_comb begin
        hit_way_o  = '0;
        hit_line_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit_i[w]) begin
                hit_way_o  = WAY_W'(w);
                hit_line_o = way_line_i[w];
            end
        end
    end

    // plru needs the valid bits to prefer an empty way
    assign valid_vec_o = way_valid_i;

    // victim fields for write back and the miss decision
    assign victim_tag_o   = way_tag_i[victim_way_i];
    assign victim_dirty_o = way_dirty_i[victim_way_i];
    assign victim_valid_o = way_valid_i[victim_way_i];
    assign victim_line_o  = way_line_i[victim_way_i];
endmodule

// File: icache_plru.sv
`timescale 1ns/100ps

module icache_plru #(
    parameter int NUM_WAYS = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  logic [NUM_WAYS-1:0]            valid_vec_i,
    input  logic                           touch_i,
    input  logic [$clog2(NUM_WAYS)-1:0]    touch_way_i,
    output logic [$clog2(NUM_WAYS)-1:0]    victim_way_o
);

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int NODES = NUM_WAYS - 1; // heap order, children of n at 2n+1 and 2n+2

    logic [icache_pkg::NUM_SETS-1:0][NODES-1:0] tree_q;
    logic [NODES-1:0] tree_cur, tree_upd;
    logic [WAY_W-1:0] tree_way;

    assign tree_cur = tree_q[index_i];

    // follow the node bits down to a leaf, msb of the way first
    always_comb begin : walk
        int node;
        node     = 0;
        tree_way = '0;
        for (int l = 0; l < WAY_W; l++) begin
            tree_way[WAY_W-1-l] = tree_cur[node];
            node = 2 * node + 1 + int'(tree_cur[node]);
        end
    end

    // every node on the touched path turns away from it
    always_comb begin : update
        int   node;
        logic dir;
        node     = 0;
        tree_upd = tree_cur;
        for (int l = 0; l < WAY_W; l++) begin
            dir            = touch_way_i[WAY_W-1-l];
            tree_upd[node] = ~dir;
            node           = 2 * node + 1 + int'(dir);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else if (touch_i) begin
            tree_q[index_i] <= tree_upd;
        end
    end

    // lowest empty way wins over the tree
    always_comb begin
        victim_way_o = tree_way;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec_i[w]) victim_way_o = WAY_W'(w);
        end
    end
endmodule

// File: icache_controller.sv
`timescale 1ns/100ps

module icache_controller #(
    parameter int NUM_WAYS = 4
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // cpu side
    input  logic                               cpu_valid_i,
    input  logic                               cpu_rw_i,    // 1 = write
    input  logic [icache_pkg::WORD_W-1:0]      cpu_addr_i,
    input  logic [icache_pkg::WORD_W-1:0]      cpu_wdata_i,
    output logic                               cpu_ready_o,
    output logic [icache_pkg::WORD_W-1:0]      cpu_rdata_o,
    output logic                               stall_o,
    // memory side
    input  logic                               mem_ready_i,
    input  logic [icache_pkg::LINE_W-1:0]      mem_rdata_i,
    output logic                               mem_valid_o,
    output logic                               mem_rw_o,
    output logic [icache_pkg::WORD_W-1:0]      mem_addr_o,
    output logic [icache_pkg::LINE_W-1:0]      mem_wdata_o,
    // from the merge
    input  logic                               hit_i,
    input  logic [$clog2(NUM_WAYS)-1:0]        hit_way_i,
    input  logic [icache_pkg::LINE_W-1:0]      hit_line_i,
    input  logic [$clog2(NUM_WAYS)-1:0]        victim_way_i,
    input  logic [icache_pkg::TAG_W-1:0]       victim_tag_i,
    input  logic                               victim_dirty_i,
    input  logic                               victim_valid_i,
    input  logic [icache_pkg::LINE_W-1:0]      victim_line_i,
    // to the ways
    output logic [icache_pkg::INDEX_W-1:0]     index_o,
    output logic [icache_pkg::TAG_W-1:0]       tag_o,
    output logic [NUM_WAYS-1:0]                way_we_o,
    output logic [icache_pkg::TAG_W-1:0]       wr_tag_o,
    output logic                               wr_dirty_o,
    output logic [icache_pkg::LINE_W-1:0]      wr_line_o,
    // to the plru
    output logic                               touch_o,
    output logic [$clog2(NUM_WAYS)-1:0]        touch_way_o,
    // statistics
    output logic [31:0]                        access_cnt_o,
    output logic [31:0]                        miss_cnt_o,
    output logic [31:0]                        hit_cnt_o
);

    localparam logic [1:0] IDLE        = 2'd0;
    localparam logic [1:0] COMPARE_TAG = 2'd1;
    localparam logic [1:0] ALLOCATE    = 2'd2;
    localparam logic [1:0] WRITE_BACK  = 2'd3;

    logic [1:0] state_q, state_d;

    icache_pkg::icache_addr_u addr;    // current cpu request
    icache_pkg::icache_addr_u wb_addr; // victim line address
    icache_pkg::icache_addr_u rd_addr; // line fill address

    logic [icache_pkg::LINE_W-1:0] merged_line; // hit line with write word
    logic [31:0] access_q, miss_q;
    logic        access_inc, miss_inc;

    assign addr.raw = cpu_addr_i;
    assign index_o  = addr.f.index;
    assign tag_o    = addr.f.tag;

    // line aligned addresses for the memory side
    always_comb begin
        wb_addr.f.tag      = victim_tag_i;
        wb_addr.f.index    = addr.f.index;
        wb_addr.f.word     = 2'b00;
        wb_addr.f.byte_off = 2'b00;
        rd_addr.raw        = addr.raw;
        rd_addr.f.word     = 2'b00; // whole line from word 0
        rd_addr.f.byte_off = 2'b00;
    end

    // word select and write merge
    assign cpu_rdata_o = hit_line_i[addr.f.word*icache_pkg::WORD_W +: icache_pkg::WORD_W];

    always_comb begin
        merged_line = hit_line_i;
        merged_line[addr.f.word*icache_pkg::WORD_W +: icache_pkg::WORD_W] = cpu_wdata_i;
    end

    // request level held while waiting on memory
    assign mem_valid_o = (state_q == ALLOCATE) || (state_q == WRITE_BACK);
    assign mem_rw_o    = (state_q == WRITE_BACK);
    assign mem_addr_o  = mem_rw_o ? wb_addr.raw : rd_addr.raw;
    assign mem_wdata_o = victim_line_i; // only looked at during write back

    assign stall_o = (state_q != IDLE) && !cpu_ready_o;

    always_comb begin
        state_d     = state_q;
        cpu_ready_o = 1'b0;
        way_we_o    = '0;
        wr_tag_o    = addr.f.tag; // a fill or a write hit both store the cpu tag
        wr_dirty_o  = 1'b0;
        wr_line_o   = merged_line;
        touch_o     = 1'b0;
        touch_way_o = hit_way_i;
        access_inc  = 1'b0;
        miss_inc    = 1'b0;

        case (state_q)
            IDLE: begin
                if (cpu_valid_i) begin
                    access_inc = 1'b1;
                    state_d    = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                if (hit_i) begin
                    cpu_ready_o = 1'b1;
                    touch_o     = 1'b1;
                    if (cpu_rw_i) begin
                        way_we_o[hit_way_i] = 1'b1; // merged word into the hit way
                        wr_dirty_o          = 1'b1;
                    end
                    state_d = IDLE;
                end else begin
                    miss_inc = 1'b1;
                    // dirty victim goes out first
                    if (victim_valid_i && victim_dirty_i) begin
                        state_d = WRITE_BACK;
                    end else begin
                        state_d = ALLOCATE;
                    end
                end
            end
            ALLOCATE: begin
                if (mem_ready_i) begin
                    way_we_o[victim_way_i] = 1'b1;
                    wr_line_o              = mem_rdata_i; // fresh line, clean
                    touch_o                = 1'b1;
                    touch_way_o            = victim_way_i;
                    state_d                = COMPARE_TAG; // compare again, now hits
                end
            end
            WRITE_BACK: begin
                if (mem_ready_i) begin
                    state_d = ALLOCATE; // read follows straight away
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            access_q <= '0;
            miss_q   <= '0;
        end else begin
            state_q <= state_d;
            if (access_inc) begin
                access_q <= access_q + 32'd1;
            end
            if (miss_inc) begin
                miss_q <= miss_q + 32'd1;
            end
        end
    end

    assign access_cnt_o = access_q;
    assign miss_cnt_o   = miss_q;
    assign hit_cnt_o    = access_q - miss_q; // second compare after a fill not counted
endmodule

// File: icache_top.sv
`timescale 1ns/100ps

module icache_top #(
    parameter int NUM_WAYS = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          cpu_valid_i,
    input  logic                          cpu_rw_i,
    input  logic [icache_pkg::WORD_W-1:0] cpu_addr_i,
    input  logic [icache_pkg::WORD_W-1:0] cpu_wdata_i,
    input  logic                          mem_ready_i,
    input  logic [icache_pkg::LINE_W-1:0] mem_rdata_i,
    output logic                          cpu_ready_o,
    output logic [icache_pkg::WORD_W-1:0] cpu_rdata_o,
    output logic                          stall_o,
    output logic                          mem_valid_o,
    output logic                          mem_rw_o,
    output logic [icache_pkg::WORD_W-1:0] mem_addr_o,
    output logic [icache_pkg::LINE_W-1:0] mem_wdata_o,
    output logic [31:0]                   access_cnt_o,
    output logic [31:0]                   miss_cnt_o,
    output logic [31:0]                   hit_cnt_o
);

    localparam int WAY_W = $clog2(NUM_WAYS);

    // controller to ways
    logic [icache_pkg::INDEX_W-1:0] index;
    logic [icache_pkg::TAG_W-1:0]   tag, wr_tag;
    logic [NUM_WAYS-1:0]            way_we;
    logic                           wr_dirty;
    logic [icache_pkg::LINE_W-1:0]  wr_line;

    // ways to merge
    logic [NUM_WAYS-1:0]                         way_hit, way_valid, way_dirty;
    logic [NUM_WAYS-1:0][icache_pkg::TAG_W-1:0]  way_tag;
    logic [NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] way_line;

    // merge and plru to controller
    logic                          hit, victim_dirty, victim_valid;
    logic [WAY_W-1:0]              hit_way, victim_way, touch_way;
    logic [icache_pkg::LINE_W-1:0] hit_line, victim_line;
    logic [icache_pkg::TAG_W-1:0]  victim_tag;
    logic [NUM_WAYS-1:0]           valid_vec;
    logic                          touch;

    icache_controller #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
        .clk_i, .rst_ni,
        .cpu_valid_i, .cpu_rw_i, .cpu_addr_i, .cpu_wdata_i,
        .cpu_ready_o, .cpu_rdata_o, .stall_o,
        .mem_ready_i, .mem_rdata_i,
        .mem_valid_o, .mem_rw_o, .mem_addr_o, .mem_wdata_o,
        .hit_i(hit), .hit_way_i(hit_way), .hit_line_i(hit_line),
        .victim_way_i(victim_way), .victim_tag_i(victim_tag),
        .victim_dirty_i(victim_dirty), .victim_valid_i(victim_valid),
        .victim_line_i(victim_line),
        .index_o(index), .tag_o(tag), .way_we_o(way_we),
        .wr_tag_o(wr_tag), .wr_dirty_o(wr_dirty), .wr_line_o(wr_line),
        .touch_o(touch), .touch_way_o(touch_way),
        .access_cnt_o, .miss_cnt_o, .hit_cnt_o
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way u_way (
            .clk_i, .rst_ni,
            .index_i(index), .tag_i(tag), .we_i(way_we[w]),
            .wr_tag_i(wr_tag), .wr_dirty_i(wr_dirty), .wr_line_i(wr_line),
            .hit_o(way_hit[w]), .valid_o(way_valid[w]), .dirty_o(way_dirty[w]),
            .tag_o(way_tag[w]), .line_o(way_line[w])
        );
    end

    icache_hit_merge #(.NUM_WAYS(NUM_WAYS)) u_merge (
        .way_hit_i(way_hit), .way_valid_i(way_valid), .way_dirty_i(way_dirty),
        .way_tag_i(way_tag), .way_line_i(way_line), .victim_way_i(victim_way),
        .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line),
        .valid_vec_o(valid_vec), .victim_tag_o(victim_tag),
        .victim_dirty_o(victim_dirty), .victim_valid_o(victim_valid),
        .victim_line_o(victim_line)
    );

    icache_plru #(.NUM_WAYS(NUM_WAYS)) u_plru (
        .clk_i, .rst_ni,
        .index_i(index), .valid_vec_i(valid_vec),
        .touch_i(touch), .touch_way_i(touch_way),
        .victim_way_o(victim_way)
    );
endmodule

// File: icache_props.sv
`timescale 1ns/100ps

module icache_props (
    input logic clk_i,
    input logic rst_ni,
    input logic ready_i,
    input logic stall_i,
    input logic mem_valid_i,
    input logic mem_ready_i
);

    int fail_cnt = 0; // read by the testbench at the end

    ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_i |=> !ready_i)
        else begin
            $error("cpu_ready_o stayed high for a second cycle");
            fail_cnt++;
        end

    // request level waits for the memory
    mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_valid_i && !mem_ready_i |=> mem_valid_i)
        else begin
            $error("mem_valid_o dropped before mem_ready_i");
            fail_cnt++;
        end

    stall_vs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(stall_i && ready_i))
        else begin
            $error("stall_o and cpu_ready_o high together");
            fail_cnt++;
        end
endmodule

bind icache_top icache_props u_props (
    .clk_i, .rst_ni, .ready_i(cpu_ready_o), .stall_i(stall_o),
    .mem_valid_i(mem_valid_o), .mem_ready_i
);

// File: icache_checker.sv
`timescale 1ns/100ps

module icache_checker #(
    parameter int EXP_WB = 0 // write-backs the table should cause
) (
    input  logic         clk_i,
    input  logic         valid_i,      // cpu request level
    input  logic         rw_i,         // 1 = write
    input  logic [31:0]  addr_i,
    input  logic [31:0]  wdata_i,
    input  logic         ready_i,
    input  logic [31:0]  rdata_i,
    input  logic         stall_i,      // request pending level
    input  logic         mem_valid_i,
    input  logic         mem_rw_i,
    input  logic         mem_ready_i,
    input  logic [31:0]  mem_addr_i,
    input  logic [127:0] mem_wdata_i,
    input  logic [31:0]  access_cnt_i,
    input  logic [31:0]  miss_cnt_i,
    input  logic [31:0]  hit_cnt_i,
    input  logic [63:0]  name_i,       // eight character test name
    input  logic         exp_miss_i,
    input  logic         done_i,       // table finished
    output int           err_cnt_o
);

    logic [31:0] shadow [logic [29:0]]; // last value the cpu wrote, per word address
    logic        busy = 1'b0;
    logic        saw_mem = 1'b0;
    logic        final_done = 1'b0;
    int          cycles = 0;
    int          rows = 0;
    int          miss_rows = 0;
    int          wbs = 0;
    int          errs = 0;

    assign err_cnt_o = errs;

    // untouched words still hold the memory fill pattern
    function automatic logic [31:0] expected_word(logic [29:0] wa);
        if (shadow.exists(wa)) return shadow[wa];
        return {2'b00, wa} ^ 32'h5a5a_0f0f;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h, actual %h", name_i, what, exp, act);
            errs++;
        end
    endtask

    // sampled on the rising edge, before the dut registers move
    always @(posedge clk_i) begin
        if (busy) begin
            cycles++;
            if (mem_valid_i) saw_mem = 1'b1; // memory was asked, so a miss
            // stall covers every cycle of the request except the answer
            check_value("stall", 32'(!ready_i), 32'(stall_i));
            if (ready_i) begin
                busy = 1'b0;
                check_value("miss", 32'(exp_miss_i), 32'(saw_mem));
                if (!exp_miss_i && cycles != 1) begin
                    $display("hit %s answered %0d cycles after acceptance", name_i, cycles);
                    errs++;
                end
                if (rw_i) begin
                    shadow[addr_i[31:2]] = wdata_i;
                end else begin
                    check_value("rdata", expected_word(addr_i[31:2]), rdata_i);
                end
            end
        end else if (valid_i) begin
            check_value("stall", 32'd0, 32'(stall_i)); // still idle at this edge
            busy    = 1'b1; // dut is idle here, so this edge accepts
            saw_mem = 1'b0;
            cycles  = 0;
            rows++;
            if (exp_miss_i) miss_rows++;
        end
        // victim line must match what the cpu left at that address
        if (mem_valid_i && mem_rw_i && mem_ready_i) begin
            wbs++;
            for (int w = 0; w < 4; w++) begin
                check_value("wb word", expected_word({mem_addr_i[31:4], w[1:0]}),
                            mem_wdata_i[w*32 +: 32]);
            end
        end
        if (done_i && !final_done) begin
            final_done = 1'b1;
            check_value("access_cnt", rows, access_cnt_i);
            check_value("miss_cnt", miss_rows, miss_cnt_i);
            check_value("hit_cnt", rows - miss_rows, hit_cnt_i);
            check_value("wb count", EXP_WB, wbs);
        end
    end
endmodule

// File: icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

    localparam int NUM_ROWS = 14;
    localparam int TIMEOUT  = 100; // cycles allowed per request
    localparam logic [31:0] FILL_KEY = 32'h5a5a_0f0f;

    logic         clk_i = 1'b0;
    logic         rst_ni = 1'b0;
    logic         cpu_valid_i = 1'b0;
    logic         cpu_rw_i = 1'b0;
    logic [31:0]  cpu_addr_i = '0;
    logic [31:0]  cpu_wdata_i = '0;
    logic         mem_ready_i = 1'b0;
    logic [127:0] mem_rdata_i = '0;
    logic         cpu_ready_o, stall_o, mem_valid_o, mem_rw_o;
    logic [31:0]  cpu_rdata_o, mem_addr_o, access_cnt_o, miss_cnt_o, hit_cnt_o;
    logic [127:0] mem_wdata_o;

    logic [129:0] stim_table [NUM_ROWS]; // name, address, rw, write data, miss
    logic [127:0] mem_lines [logic [27:0]];
    logic [31:0]  rng = 32'h28cf_27fe;
    logic [63:0]  row_name = '0;
    logic         row_miss = 1'b0;
    logic         mem_busy = 1'b0;
    logic         done = 1'b0;
    int           mem_wait = 0;
    int           timeouts = 0;
    int           chk_errs;
    icache_pkg::icache_addr_u maddr;

    always #5 clk_i = ~clk_i;

    icache_top dut (.*);

    icache_checker #(.EXP_WB(3)) chk (
        .clk_i, .valid_i(cpu_valid_i), .rw_i(cpu_rw_i), .addr_i(cpu_addr_i),
        .wdata_i(cpu_wdata_i), .ready_i(cpu_ready_o), .rdata_i(cpu_rdata_o),
        .stall_i(stall_o),
        .mem_valid_i(mem_valid_o), .mem_rw_i(mem_rw_o), .mem_ready_i,
        .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o),
        .access_cnt_i(access_cnt_o), .miss_cnt_i(miss_cnt_o), .hit_cnt_i(hit_cnt_o),
        .name_i(row_name), .exp_miss_i(row_miss), .done_i(done), .err_cnt_o(chk_errs)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // first touch fills a line from its own word addresses
    function automatic logic [127:0] fetch_line(logic [27:0] la);
        logic [127:0] line;
        if (!mem_lines.exists(la)) begin
            for (int w = 0; w < 4; w++) begin
                line[w*32 +: 32] = {2'b00, la, w[1:0]} ^ FILL_KEY;
            end
            mem_lines[la] = line;
        end
        return mem_lines[la];
    endfunction

    // memory model, answers after 1 to 6 cycles
    always @(negedge clk_i) begin
        if (mem_ready_i) begin
            mem_ready_i = 1'b0; // one cycle pulse
            mem_busy    = 1'b0;
        end else if (mem_valid_o) begin
            if (!mem_busy) begin
                rng      = xorshift32(rng);
                mem_wait = 1 + int'(rng % 6);
                mem_busy = 1'b1;
            end
            mem_wait--;
            if (mem_wait == 0) begin
                maddr.raw = mem_addr_o;
                if (mem_rw_o) begin
                    mem_lines[{maddr.f.tag, maddr.f.index}] = mem_wdata_o;
                end else begin
                    mem_rdata_i = fetch_line({maddr.f.tag, maddr.f.index});
                end
                mem_ready_i = 1'b1;
            end
        end
    end

    task automatic wait_ready(input logic [63:0] name);
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!cpu_ready_o && n < TIMEOUT);
        if (!cpu_ready_o) begin
            $display("request %s got no cpu_ready_o within %0d cycles", name, TIMEOUT);
            timeouts++;
        end
    endtask

    initial begin
        stim_table[0]  = {"rd_cold0", 32'h0000_0104, 1'b0, 32'h0000_0000, 1'b1};
        stim_table[1]  = {"rd_hit_0", 32'h0000_0108, 1'b0, 32'h0000_0000, 1'b0};
        stim_table[2]  = {"rd_cold1", 32'h0000_0214, 1'b0, 32'h0000_0000, 1'b1};
        stim_table[3]  = {"wr_hit_0", 32'h0000_0108, 1'b1, 32'hcafe_0001, 1'b0};
        stim_table[4]  = {"rd_wrote", 32'h0000_0108, 1'b0, 32'h0000_0000, 1'b0};
        stim_table[5]  = {"rd_other", 32'h0000_010c, 1'b0, 32'h0000_0000, 1'b0};
        // five tags into set 3, way 0 is the first plru victim
        stim_table[6]  = {"wr_fill0", 32'h1000_0030, 1'b1, 32'h1111_0000, 1'b1};
        stim_table[7]  = {"wr_fill1", 32'h2000_0030, 1'b1, 32'h2222_0000, 1'b1};
        stim_table[8]  = {"wr_fill2", 32'h3000_0034, 1'b1, 32'h3333_0000, 1'b1};
        stim_table[9]  = {"wr_fill3", 32'h4000_0030, 1'b1, 32'h4444_0000, 1'b1};
        stim_table[10] = {"wr_evict", 32'h5000_0030, 1'b1, 32'h5555_0000, 1'b1};
        stim_table[11] = {"rd_evict", 32'h1000_0030, 1'b0, 32'h0000_0000, 1'b1};
        stim_table[12] = {"rd_again", 32'h1000_0034, 1'b0, 32'h0000_0000, 1'b0};
        stim_table[13] = {"rd_refil", 32'h3000_0034, 1'b0, 32'h0000_0000, 1'b1};

        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;

        for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
            {row_name, cpu_addr_i, cpu_rw_i, cpu_wdata_i, row_miss} = stim_table[r];
            cpu_valid_i = 1'b1;
            wait_ready(row_name);
            @(negedge clk_i); // answer taken at the rising edge before
        end
        cpu_valid_i = 1'b0;
        done        = 1'b1;
        repeat (2) @(negedge clk_i);

        $display("checker errors %0d, assertion failures %0d, timeouts %0d",
                 chk_errs, dut.u_props.fail_cnt, timeouts);
        if (chk_errs == 0 && dut.u_props.fail_cnt == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end
endmodule

// File: icache.f
icache_pkg.sv
icache_way.sv
icache_hit_merge.sv
icache_plru.sv
icache_controller.sv
icache_top.sv
icache_props.sv
icache_checker.sv
icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_way.sv
  - icache_hit_merge.sv
  - icache_plru.sv
  - icache_controller.sv
  - icache_top.sv
  - target: test
    files:
      - icache_props.sv
      - icache_checker.sv
      - icache_tb.sv
